/* ahb_fabric_pkg.sv */
// Shared widths, AHB-Lite encodings and payload structs for the bus front end.
// Every module of the fabric pulls these in by wildcard import.

package ahb_fabric_pkg;

	// ------------------------------------------------------------------
	// Sizes

	// Number of requester ports on the fabric
	localparam int unsigned N_PORTS = 3;

	// Bus widths
	localparam int unsigned W_ADDR = 32;
	localparam int unsigned W_DATA = 32;

	// ------------------------------------------------------------------
	// AHB-Lite encodings

	// Transfer type as driven on HTRANS
	typedef logic [1:0] htrans_t;

	localparam htrans_t HTRANS_IDLE = 2'b00;
	localparam htrans_t HTRANS_NSEQ = 2'b10;

	// Single transfers only, no bursts
	localparam logic [2:0] HBURST_SINGLE = 3'b000;

	// ------------------------------------------------------------------
	// Payloads

	// Client request, as taken on the request stream
	typedef struct packed {
		logic [W_ADDR-1:0] addr;
		logic              write;
		// HSIZE encoding, byte count is 1 << size
		logic [2:0]        size;
		logic [3:0]        prot;
		logic [W_DATA-1:0] wdata;
	} ahb_req_t;

	// Address-phase part of a request, no write data
	typedef struct packed {
		logic [W_ADDR-1:0] addr;
		logic              write;
		logic [2:0]        size;
		logic [3:0]        prot;
	} ahb_aph_t;

	// Response handed back to the client
	typedef struct packed {
		// Read data, don't care on writes
		logic [W_DATA-1:0] rdata;
		// Set when the slave answered HRESP high
		logic              err;
	} ahb_resp_t;

endpackage

/* ahb_req_port.sv */
// One requester port of the fabric. Buffers a single client request, asks
// the arbiter for the bus, keeps write data stable through the data phase
// and holds the response until the client takes it.

module ahb_req_port
	import ahb_fabric_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	// Client request stream
	input  logic              req_valid_i,
	output logic              req_ready_o,
	input  ahb_req_t          req_i,

	// Client response stream
	output logic              resp_valid_o,
	input  logic              resp_ready_i,
	output ahb_resp_t         resp_o,

	// Towards arbiter and master mux
	output logic              bus_req_o,
	output ahb_aph_t          aph_o,
	output logic [W_DATA-1:0] wdata_o,

	// Back from the master mux
	input  logic              aph_done_i,
	input  logic              dph_done_i,
	input  ahb_resp_t         bus_resp_i
);

	// ------------------------------------------------------------------
	// Port state machine

	typedef enum logic [1:0] {
		ST_EMPTY,
		ST_REQ,
		ST_DPH,
		ST_RESP
	} port_state_t;

	port_state_t state_q;
	port_state_t state_d;

	// Buffered request and captured response
	ahb_req_t    req_q;
	ahb_resp_t   resp_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			// Idle, waiting for a client request
			ST_EMPTY: if (req_valid_i) state_d = ST_REQ;
			// Asking for the bus until address phase accepted
			ST_REQ:   if (aph_done_i)  state_d = ST_DPH;
			// Own the data phase, wait for HREADY
			ST_DPH:   if (dph_done_i)  state_d = ST_RESP;
			// Response held, port blocked until taken
			ST_RESP:  if (resp_ready_i) state_d = ST_EMPTY;
			default:  state_d = ST_EMPTY;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_EMPTY;
		end else begin
			state_q <= state_d;
		end
	end

	// Payload registers, loaded on handshakes only
	always_ff @(posedge clk) begin
		if (req_valid_i && req_ready_o) begin
			req_q <= req_i;
		end
	end

	always_ff @(posedge clk) begin
		if (dph_done_i) begin
			resp_q <= bus_resp_i;
		end
	end

	// ------------------------------------------------------------------
	// Outputs

	// Only one transfer at a time per port
	assign req_ready_o  = (state_q == ST_EMPTY);
	assign bus_req_o    = (state_q == ST_REQ);
	assign resp_valid_o = (state_q == ST_RESP);
	assign resp_o       = resp_q;

	// Address phase view of the buffered request
	assign aph_o.addr  = req_q.addr;
	assign aph_o.write = req_q.write;
	assign aph_o.size  = req_q.size;
	assign aph_o.prot  = req_q.prot;

	// Held in req_q until the next accept, so stable through data phase
	assign wdata_o = req_q.wdata;

	// ------------------------------------------------------------------
	// Checks

	// Mux must only accept an address phase we are asking for
	a_aph_done_in_req: assert property (@(posedge clk) disable iff (!rst_n)
		aph_done_i |-> (state_q == ST_REQ));

	// Client keeps a stalled request valid and unchanged
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_i)));

endmodule

/* ahb_prio_arbiter.sv */
// Fixed-priority arbiter for the AHB-Lite master port. Lowest requesting
// index wins. A grant given while HREADY is low is repeated on the next
// cycle so the stalled address phase stays on the bus.

module ahb_prio_arbiter
	import ahb_fabric_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,

	// One request line per port
	input  logic [N_PORTS-1:0] bus_req_i,
	// Bus stall, low extends the current address phase
	input  logic               hready_i,

	// One-hot grant, all zero when nobody asks
	output logic [N_PORTS-1:0] gnt_o
);

	// ------------------------------------------------------------------
	// Priority pick

	logic [N_PORTS-1:0] gnt_pick;

	// Scan from the top so the lowest index is the last to write
	always_comb begin
		gnt_pick = '0;
		for (int i = N_PORTS - 1; i >= 0; i--) begin
			if (bus_req_i[i]) begin
				gnt_pick    = '0;
				gnt_pick[i] = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Hold across a stalled address phase

	// Set when last cycle had a transfer on the bus with HREADY low
	logic               hold_q;
	// Grant seen on the bus last cycle
	logic [N_PORTS-1:0] gnt_prev_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_q     <= 1'b0;
			gnt_prev_q <= '0;
		end else begin
			// Any grant means NSEQ is on the bus this cycle
			hold_q     <= (|gnt_o) && !hready_i;
			gnt_prev_q <= gnt_o;
		end
	end

	// Held port still asserts its request, it only leaves on aph_done
	assign gnt_o = hold_q ? gnt_prev_q : gnt_pick;

	// ------------------------------------------------------------------
	// Checks

	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt_o));

endmodule

/* ahb_master_mux.sv */
// Drives the single AHB-Lite master port from the granted requester port.
// Tracks which port owns the data phase and returns done strobes plus the
// shared response (HRDATA, HRESP) to the ports.

module ahb_master_mux
	import ahb_fabric_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,

	// From arbiter and ports
	input  logic [N_PORTS-1:0] gnt_i,
	input  ahb_aph_t           aph_i   [N_PORTS],
	input  logic [W_DATA-1:0]  wdata_i [N_PORTS],

	// Back to ports
	output logic [N_PORTS-1:0] aph_done_o,
	output logic [N_PORTS-1:0] dph_done_o,
	output ahb_resp_t          resp_o,

	// AHB-Lite master
	output logic [W_ADDR-1:0]  haddr_o,
	output logic               hwrite_o,
	output htrans_t            htrans_o,
	output logic [2:0]         hsize_o,
	output logic [2:0]         hburst_o,
	output logic [3:0]         hprot_o,
	output logic               hmastlock_o,
	output logic [W_DATA-1:0]  hwdata_o,
	input  logic               hready_i,
	input  logic               hresp_i,
	input  logic [W_DATA-1:0]  hrdata_i
);

	// ------------------------------------------------------------------
	// Address phase

	ahb_aph_t aph_sel;

	// Zeros when idle
	always_comb begin
		aph_sel = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			if (gnt_i[i]) begin
				aph_sel = aph_i[i];
			end
		end
	end

	assign htrans_o    = (|gnt_i) ? HTRANS_NSEQ : HTRANS_IDLE;
	assign haddr_o     = aph_sel.addr;
	assign hwrite_o    = aph_sel.write;
	assign hsize_o     = aph_sel.size;
	assign hprot_o     = aph_sel.prot;
	assign hburst_o    = HBURST_SINGLE;
	assign hmastlock_o = 1'b0;

	// ------------------------------------------------------------------
	// Data phase ownership

	// Address phase accepted on HREADY becomes the next data phase
	logic [N_PORTS-1:0] dph_own_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_own_q <= '0;
		end else if (hready_i) begin
			dph_own_q <= gnt_i;
		end
	end

	logic [W_DATA-1:0] wdata_sel;

	// Owner's write data, held by the port through the data phase
	always_comb begin
		wdata_sel = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			if (dph_own_q[i]) begin
				wdata_sel = wdata_i[i];
			end
		end
	end

	assign hwdata_o = wdata_sel;

	// ------------------------------------------------------------------
	// Response routing

	assign aph_done_o = gnt_i & {N_PORTS{hready_i}};
	assign dph_done_o = dph_own_q & {N_PORTS{hready_i}};

	// Shared by all ports, only the owner samples it
	assign resp_o.rdata = hrdata_i;
	assign resp_o.err   = hresp_i;

	// Stalled address phase must stay put until HREADY
	a_aph_stable: assert property (@(posedge clk) disable iff (!rst_n)
		((htrans_o == HTRANS_NSEQ) && !hready_i) |=>
		((htrans_o == HTRANS_NSEQ) && $stable(haddr_o) && $stable(hwrite_o) &&
		 $stable(hsize_o) && $stable(hprot_o)));

endmodule

/* ahb_fabric_top.sv */
// Top level of the AHB-Lite front end. N_PORTS client ports share one
// AHB-Lite master through a fixed-priority arbiter and the master mux.
// Clients use valid/ready for requests and for responses.

module ahb_fabric_top
	import ahb_fabric_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,

	// Client ports
	input  logic [N_PORTS-1:0] req_valid_i,
	output logic [N_PORTS-1:0] req_ready_o,
	input  ahb_req_t           req_i        [N_PORTS],
	output logic [N_PORTS-1:0] resp_valid_o,
	input  logic [N_PORTS-1:0] resp_ready_i,
	output ahb_resp_t          resp_o       [N_PORTS],

	// AHB-Lite master
	output logic [W_ADDR-1:0]  haddr_o,
	output logic               hwrite_o,
	output htrans_t            htrans_o,
	output logic [2:0]         hsize_o,
	output logic [2:0]         hburst_o,
	output logic [3:0]         hprot_o,
	output logic               hmastlock_o,
	output logic [W_DATA-1:0]  hwdata_o,
	input  logic               hready_i,
	input  logic               hresp_i,
	input  logic [W_DATA-1:0]  hrdata_i
);

	// ------------------------------------------------------------------
	// Internal wiring

	logic [N_PORTS-1:0] bus_req;
	logic [N_PORTS-1:0] gnt;
	logic [N_PORTS-1:0] aph_done;
	logic [N_PORTS-1:0] dph_done;
	ahb_aph_t           aph      [N_PORTS];
	logic [W_DATA-1:0]  wdata    [N_PORTS];
	ahb_resp_t          bus_resp;

	ahb_prio_arbiter u_arb (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_req_i (bus_req),
		.hready_i  (hready_i),
		.gnt_o     (gnt)
	);

	// One buffered requester per client
	for (genvar p = 0; p < N_PORTS; p++) begin : g_port
		ahb_req_port u_port (
			.clk          (clk),
			.rst_n        (rst_n),
			.req_valid_i  (req_valid_i[p]),
			.req_ready_o  (req_ready_o[p]),
			.req_i        (req_i[p]),
			.resp_valid_o (resp_valid_o[p]),
			.resp_ready_i (resp_ready_i[p]),
			.resp_o       (resp_o[p]),
			.bus_req_o    (bus_req[p]),
			.aph_o        (aph[p]),
			.wdata_o      (wdata[p]),
			.aph_done_i   (aph_done[p]),
			.dph_done_i   (dph_done[p]),
			.bus_resp_i   (bus_resp)
		);
	end

	ahb_master_mux u_mux (
		.clk         (clk),
		.rst_n       (rst_n),
		.gnt_i       (gnt),
		.aph_i       (aph),
		.wdata_i     (wdata),
		.aph_done_o  (aph_done),
		.dph_done_o  (dph_done),
		.resp_o      (bus_resp),
		.haddr_o     (haddr_o),
		.hwrite_o    (hwrite_o),
		.htrans_o    (htrans_o),
		.hsize_o     (hsize_o),
		.hburst_o    (hburst_o),
		.hprot_o     (hprot_o),
		.hmastlock_o (hmastlock_o),
		.hwdata_o    (hwdata_o),
		.hready_i    (hready_i),
		.hresp_i     (hresp_i),
		.hrdata_i    (hrdata_i)
	);

endmodule

/* tb_ahb_mem.sv */
// AHB-Lite slave memory for the testbench. Adds 0 to 3 wait states per
// transfer at random and answers HRESP high for the window at 0xFFFFFFxx.

module tb_ahb_mem
	import ahb_fabric_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [W_ADDR-1:0] haddr_i,
	input  logic              hwrite_i,
	input  htrans_t           htrans_i,
	input  logic [W_DATA-1:0] hwdata_i,
	output logic              hready_o,
	output logic              hresp_o,
	output logic [W_DATA-1:0] hrdata_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// 256 words, client regions selected by address bits 9:8
	logic [W_DATA-1:0] mem [256];

	// Transfer currently in its data phase
	logic              dph_q;
	logic [W_ADDR-1:0] dph_addr_q;
	logic              dph_write_q;
	// Wait states left before HREADY goes high
	logic [1:0]        wait_q;
	logic              dph_err;
	logic              dph_good;

	assign dph_err  = dph_q && (dph_addr_q[31:8] == 24'hFF_FFFF);
	assign dph_good = dph_q && !dph_err && hready_o;
	assign hready_o = !dph_q || (wait_q == 2'd0);
	// Error only on the HREADY-high cycle
	assign hresp_o  = dph_err && hready_o;
	assign hrdata_o = (dph_good && !dph_write_q) ? mem[dph_addr_q[9:2]] : '0;

	// ------------------------------------------------------------------
	// Address phase capture

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_q       <= 1'b0;
			dph_addr_q  <= '0;
			dph_write_q <= 1'b0;
			wait_q      <= 2'd0;
		end else if (hready_o) begin
			dph_q       <= (htrans_i == HTRANS_NSEQ);
			dph_addr_q  <= haddr_i;
			dph_write_q <= hwrite_i;
			// Fresh wait count for the next data phase
			wait_q      <= 2'($urandom_range(0, 3));
		end else begin
			wait_q <= wait_q - 2'd1;
		end
	end

	// Cleared in reset, written when a good write ends
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= '0;
			end
		end else if (dph_good && dph_write_q) begin
			mem[dph_addr_q[9:2]] <= hwdata_i;
		end
	end

endmodule

/* tb_top.sv */
// Testbench for the AHB-Lite front end. Each client sends random loads and
// stores into its own region and a shared error window, a reference model
// predicts every response, and tb_ahb_mem acts as the slave.

module tb_top
	import ahb_fabric_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned N_REQ      = 200;
	localparam int unsigned RST_CYCLES = 8;
	// Budget of 20 cycles per request
	localparam int unsigned TIMEOUT    = N_PORTS * N_REQ * 20 + RST_CYCLES;
	// Port whose response ready stays low until STALL_END
	localparam int unsigned STALL_PORT = 1;
	localparam int unsigned STALL_END  = 400;
	localparam logic [31:0] SEED       = 32'hb788;

	// Expected response, rdata compared on good reads only
	typedef struct packed {
		ahb_resp_t resp;
		logic      chk_data;
	} exp_t;

	logic               clk = 1'b0;
	logic               rst_n;
	logic [N_PORTS-1:0] req_valid;
	logic [N_PORTS-1:0] req_ready;
	logic [N_PORTS-1:0] resp_valid;
	logic [N_PORTS-1:0] resp_ready;
	ahb_req_t           req  [N_PORTS];
	ahb_resp_t          resp [N_PORTS];
	logic [W_ADDR-1:0]  haddr;
	logic               hwrite;
	htrans_t            htrans;
	logic [2:0]         hsize;
	logic [2:0]         hburst;
	logic [3:0]         hprot;
	logic               hmastlock;
	logic [W_DATA-1:0]  hwdata;
	logic [W_DATA-1:0]  hrdata;
	logic               hready;
	logic               hresp;

	// Reference model and bookkeeping
	logic [W_DATA-1:0]  ref_mem [N_PORTS][16];
	exp_t               exp_q   [N_PORTS][$];
	logic               pend    [N_PORTS];
	int unsigned        n_acc   [N_PORTS];
	int unsigned        n_rsp   [N_PORTS];
	int unsigned        err_cnt = 0;
	int unsigned        cycle   = 0;

	// Accepted request and whether it still waits for its address phase
	ahb_req_t           acc_req [N_PORTS];
	logic               in_req  [N_PORTS];
	// Last cycle ended with an address phase stalled by HREADY low
	logic               aph_held  = 1'b0;
	int                 held_port = 0;

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	ahb_fabric_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_valid_i  (req_valid),
		.req_ready_o  (req_ready),
		.req_i        (req),
		.resp_valid_o (resp_valid),
		.resp_ready_i (resp_ready),
		.resp_o       (resp),
		.haddr_o      (haddr),
		.hwrite_o     (hwrite),
		.htrans_o     (htrans),
		.hsize_o      (hsize),
		.hburst_o     (hburst),
		.hprot_o      (hprot),
		.hmastlock_o  (hmastlock),
		.hwdata_o     (hwdata),
		.hready_i     (hready),
		.hresp_i      (hresp),
		.hrdata_i     (hrdata)
	);

	tb_ahb_mem u_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.haddr_i  (haddr),
		.hwrite_i (hwrite),
		.htrans_i (htrans),
		.hwdata_i (hwdata),
		.hready_o (hready),
		.hresp_o  (hresp),
		.hrdata_o (hrdata)
	);

	// ------------------------------------------------------------------
	// Compare tasks

	task automatic check_resp(input int unsigned port, input ahb_resp_t got,
		input ahb_resp_t exp, input logic chk_data);
		if (got.err !== exp.err) begin
			$display("[ERROR] %0t resp_o[%0d].err got %b exp %b",
				$time, port, got.err, exp.err);
			err_cnt++;
		end
		if (chk_data && (got.rdata !== exp.rdata)) begin
			$display("[ERROR] %0t resp_o[%0d].rdata got %h exp %h",
				$time, port, got.rdata, exp.rdata);
			err_cnt++;
		end
	endtask

	task automatic check_htrans(input htrans_t got, input htrans_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t htrans_o got %b exp %b", $time, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_aph(input ahb_aph_t got, input ahb_aph_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t haddr/hwrite/hsize/hprot got %h exp %h",
				$time, got, exp);
			err_cnt++;
		end
	endtask

	// Single transfers, never locked
	task automatic check_ctrl(input logic [2:0] got_burst, input logic got_lock);
		if (got_burst !== HBURST_SINGLE) begin
			$display("[ERROR] %0t hburst_o got %b exp %b",
				$time, got_burst, HBURST_SINGLE);
			err_cnt++;
		end
		if (got_lock !== 1'b0) begin
			$display("[ERROR] %0t hmastlock_o got %b exp %b", $time, got_lock, 1'b0);
			err_cnt++;
		end
	endtask

	// Bus idle and no response pending
	task automatic check_idle();
		check_htrans(htrans, HTRANS_IDLE);
		if (resp_valid !== '0) begin
			$display("[ERROR] %0t resp_valid_o got %b exp %b",
				$time, resp_valid, {N_PORTS{1'b0}});
			err_cnt++;
		end
	endtask

	// ------------------------------------------------------------------
	// Stimulus and reference model

	// Word access to the port's own region, sometimes to the error window
	function automatic ahb_req_t make_req(input int unsigned port);
		ahb_req_t   r;
		logic [3:0] off;
		off     = 4'($urandom_range(0, 15));
		r.write = 1'($urandom_range(0, 1));
		r.size  = 3'b010;
		r.prot  = 4'($urandom);
		r.wdata = $urandom;
		if ($urandom_range(0, 15) == 0) begin
			r.addr = {24'hFF_FFFF, 2'b00, off, 2'b00};
		end else begin
			r.addr = {22'd0, 2'(port), 2'b00, off, 2'b00};
		end
		return r;
	endfunction

	// Model update at the request handshake
	task automatic accept_req(input int unsigned port, input ahb_req_t r);
		exp_t e;
		e = '0;
		if (exp_q[port].size() != 0) begin
			$display("%0t port %0d took a request with one still outstanding", $time, port);
			err_cnt++;
		end
		if (r.addr[31:8] == 24'hFF_FFFF) begin
			// Window has no storage behind it
			e.resp.err = 1'b1;
		end else if (r.write) begin
			ref_mem[port][r.addr[5:2]] = r.wdata;
		end else begin
			e.resp.rdata = ref_mem[port][r.addr[5:2]];
			e.chk_data   = 1'b1;
		end
		exp_q[port].push_back(e);
		acc_req[port] = r;
		in_req[port]  = 1'b1;
		n_acc[port]++;
	endtask

	task automatic take_resp(input int unsigned port);
		exp_t e;
		if (exp_q[port].size() == 0) begin
			$display("%0t port %0d returned a response nobody asked for", $time, port);
			err_cnt++;
		end else begin
			e = exp_q[port].pop_front();
			check_resp(port, resp[port], e.resp, e.chk_data);
		end
		n_rsp[port]++;
	endtask

	// Expected address phase from the fixed priority and the stall hold
	task automatic check_bus();
		int       sel;
		ahb_aph_t got;
		ahb_aph_t exp;
		sel = -1;
		if (aph_held) begin
			sel = held_port;
		end else begin
			// Lowest waiting port wins
			for (int p = 0; p < N_PORTS; p++) begin
				if ((sel < 0) && in_req[p]) begin
					sel = p;
				end
			end
		end
		got.addr  = haddr;
		got.write = hwrite;
		got.size  = hsize;
		got.prot  = hprot;
		exp       = '0;
		if (sel >= 0) begin
			exp.addr  = acc_req[sel].addr;
			exp.write = acc_req[sel].write;
			exp.size  = acc_req[sel].size;
			exp.prot  = acc_req[sel].prot;
			check_htrans(htrans, HTRANS_NSEQ);
			// Taken at the coming edge unless the slave stalls
			if (hready) begin
				in_req[sel] = 1'b0;
			end
		end else begin
			check_htrans(htrans, HTRANS_IDLE);
		end
		check_aph(got, exp);
		check_ctrl(hburst, hmastlock);
		aph_held  = (sel >= 0) && !hready;
		held_port = sel;
	endtask

	// Falling edge, new inputs then the handshakes of the next rising edge
	task automatic drive_cycle();
		for (int p = 0; p < N_PORTS; p++) begin
			if (!pend[p] && (n_acc[p] < N_REQ) && ($urandom_range(0, 3) != 0)) begin
				req[p]  = make_req(p);
				pend[p] = 1'b1;
			end
			req_valid[p] = pend[p];
			if ((p == STALL_PORT) && (cycle < STALL_END)) begin
				resp_ready[p] = 1'b0;
			end else begin
				resp_ready[p] = 1'($urandom_range(0, 1));
			end
			// Ready and valid come from port state, stable until the edge
			if (pend[p] && req_ready[p]) begin
				accept_req(p, req[p]);
				pend[p] = 1'b0;
			end
			if (resp_valid[p] && resp_ready[p]) begin
				take_resp(p);
			end
			// Held response must block new requests
			if (resp_valid[p] && req_ready[p]) begin
				$display("%0t port %0d is ready for a request while holding a response",
					$time, p);
				err_cnt++;
			end
		end
	endtask

	// End of stall window, one response held, the others moved on
	task automatic check_stall();
		if ((n_rsp[STALL_PORT] != 0) || !resp_valid[STALL_PORT]) begin
			$display("%0t stalled port %0d is not holding exactly one response",
				$time, STALL_PORT);
			err_cnt++;
		end
		for (int p = 0; p < N_PORTS; p++) begin
			if ((p != STALL_PORT) && (n_rsp[p] == 0)) begin
				$display("%0t port %0d made no progress during the stall", $time, p);
				err_cnt++;
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Main sequence

	initial begin : main
		int unsigned tot_acc;
		int unsigned tot_rsp;
		logic        done;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		req_valid  = '0;
		resp_ready = '0;
		for (int p = 0; p < N_PORTS; p++) begin
			req[p]     = '0;
			acc_req[p] = '0;
			in_req[p]  = 1'b0;
			pend[p]    = 1'b0;
			n_acc[p]   = 0;
			n_rsp[p]   = 0;
			for (int w = 0; w < 16; w++) begin
				ref_mem[p][w] = '0;
			end
		end
		repeat (RST_CYCLES) begin
			@(negedge clk);
			check_idle();
		end
		rst_n = 1'b1;
		// Nothing requested yet
		repeat (4) begin
			@(negedge clk);
			check_idle();
		end
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (cycle == STALL_END) begin
				check_stall();
			end
			check_bus();
			drive_cycle();
			done = 1'b1;
			for (int p = 0; p < N_PORTS; p++) begin
				if (n_rsp[p] != N_REQ) begin
					done = 1'b0;
				end
			end
		end
		// Last response lands, bus goes quiet
		@(negedge clk);
		req_valid  = '0;
		resp_ready = '0;
		check_idle();
		tot_acc = 0;
		tot_rsp = 0;
		for (int p = 0; p < N_PORTS; p++) begin
			tot_acc += n_acc[p];
			tot_rsp += n_rsp[p];
		end
		if (tot_acc != tot_rsp) begin
			$display("%0d requests accepted but %0d responses returned", tot_acc, tot_rsp);
			err_cnt++;
		end
		$display("errors %0d, accepted %0d, responses %0d, cycles %0d",
			err_cnt, tot_acc, tot_rsp, cycle);
		if (err_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (cycle >= TIMEOUT);
		$display("timeout after %0d cycles with transfers still open, errors %0d",
			cycle, err_cnt);
		$display("sim failed");
		$finish;
	end

endmodule

/* tb.f */
ahb_fabric_pkg.sv
ahb_req_port.sv
ahb_prio_arbiter.sv
ahb_master_mux.sv
ahb_fabric_top.sv
tb_ahb_mem.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
